//--- build.f
source/soc_map_pkg.sv
source/bus_pkg.sv
source/mem_xbar.sv
source/boot_rom.sv
source/main_memory.sv
source/debug_req_gate.sv
source/soc_top.sv
testbench/soc_top_asserts.sv
testbench/tb_soc_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the soc_top testbench with Verilator

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
BUILD_DIR=obj_dir
LOG_FILE=sim.log

cd "$ROOT_DIR" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_soc_top \
  --Mdir "$BUILD_DIR" -o Vtb_soc_top
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_soc_top" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG_FILE"; then
  exit 1
fi

if ! grep -q "Simulation PASSED" "$LOG_FILE"; then
  echo "No final result found in $LOG_FILE"
  exit 1
fi

exit 0

//--- source/boot_rom.sv
`timescale 1ns/1ps

module boot_rom (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic [soc_map_pkg::RomIdxWidth-1:0] idx_i,
  output logic [bus_pkg::DataWidth-1:0]       rdata_o
);
  import soc_map_pkg::*;
  import bus_pkg::*;

  typedef logic [RomWords-1:0][DataWidth-1:0] image_t;

  // Tag in the upper half, word number in the lower half
  function automatic image_t build_image();
    image_t img;
    for (int i = 0; i < RomWords; i++) begin
      img[i] = {BootTag, 32'(i)};
    end
    return img;
  endfunction

  localparam image_t RomImage = build_image();

  logic [DataWidth-1:0] rdata_q;

  always_ff @(posedge clk_i) begin : p_read
    if (req_i) begin
      rdata_q <= RomImage[idx_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- source/bus_pkg.sv
package bus_pkg;

  // ------------------------------------------------------------
  // Channel widths
  // ------------------------------------------------------------
  localparam int unsigned DataWidth  = 8 * soc_map_pkg::WordBytes;  // 64
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned ByteOffset = $clog2(StrbWidth);
  localparam int unsigned IdxWidth   = $clog2(soc_map_pkg::DramWords);

  // Master request, one word per transfer
  typedef struct packed {
    logic [soc_map_pkg::AddrWidth-1:0] addr;
    logic                              we;
    logic [DataWidth-1:0]              wdata;
    logic [StrbWidth-1:0]              be;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;    // Decode error
  } bus_rsp_t;

  // Target side, address already turned into a word index
  typedef struct packed {
    logic [IdxWidth-1:0]  idx;
    logic                 we;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] be;
  } mem_req_t;

endpackage

//--- source/debug_req_gate.sv
`timescale 1ns/1ps

module debug_req_gate (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [soc_map_pkg::NbHarts-1:0] debug_req_i,
  input  logic                            debug_en_i,
  output logic [soc_map_pkg::NbHarts-1:0] debug_req_o
);
  import soc_map_pkg::*;

  localparam int unsigned CntWidth = $clog2(DebugDelayCycles + 1);

  logic [CntWidth-1:0] cnt_q;
  logic                window_done;

  // Boot code runs undisturbed while the counter drains
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign window_done = (cnt_q == '0);

  // Pass through only after the window and with debug enabled
  assign debug_req_o = (window_done && debug_en_i) ? debug_req_i : '0;

endmodule

//--- source/main_memory.sv
`timescale 1ns/1ps

module main_memory (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  bus_pkg::mem_req_t             mem_i,
  output logic [bus_pkg::DataWidth-1:0] rdata_o,
  output logic [31:0]                   exit_o
);
  import soc_map_pkg::*;
  import bus_pkg::*;

  // Word index of the exit mailbox
  localparam logic [IdxWidth-1:0] ExitIdx = IdxWidth'((ExitAddr - DramBase) >> ByteOffset);

  logic [DataWidth-1:0] mem_q [DramWords];
  logic [DataWidth-1:0] rdata_q;
  logic [31:0]          exit_mask;
  logic [31:0]          exit_q;

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin : p_mem
    if (req_i) begin
      if (mem_i.we) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (mem_i.be[b]) begin
            mem_q[mem_i.idx][b*8 +: 8] <= mem_i.wdata[b*8 +: 8];
          end
        end
      end
      rdata_q <= mem_q[mem_i.idx];  // Old word on a write
    end
  end

  assign rdata_o = rdata_q;

  // ------------------------------------------------------------
  // Exit mailbox
  // ------------------------------------------------------------
  always_comb begin : p_exit_mask
    for (int b = 0; b < 4; b++) begin
      exit_mask[b*8 +: 8] = {8{mem_i.be[b]}};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_exit
    if (!rst_ni) begin
      exit_q <= '0;
    end else if (req_i && mem_i.we && (mem_i.idx == ExitIdx)) begin
      exit_q <= mem_i.wdata[31:0] & exit_mask;
    end
  end

  assign exit_o = exit_q;

endmodule

//--- source/mem_xbar.sv
`timescale 1ns/1ps

module mem_xbar (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Master side
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  bus_pkg::bus_req_t                req_i,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output bus_pkg::bus_rsp_t                rsp_o,
  // Target side
  output logic                             rom_req_o,
  output logic                             dram_req_o,
  output bus_pkg::mem_req_t                mem_req_o,
  input  logic [bus_pkg::DataWidth-1:0]    rom_rdata_i,
  input  logic [bus_pkg::DataWidth-1:0]    dram_rdata_i
);
  import soc_map_pkg::*;
  import bus_pkg::*;

  // Everything needed to build the held response
  typedef struct packed {
    logic    valid;
    logic    rd;
    region_e region;
  } rsp_state_t;

  logic                 rom_hit;
  logic                 dram_hit;
  region_e              region;
  logic [AddrWidth-1:0] offset;
  logic                 accept;
  logic                 ready_en_q;   // Low until first edge after reset
  rsp_state_t           state_d, state_q;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  assign rom_hit  = (req_i.addr >= RomBase)  && (req_i.addr < RomBase + RomLength);
  assign dram_hit = (req_i.addr >= DramBase) && (req_i.addr < DramBase + DramLength);

  always_comb begin : p_decode
    if (rom_hit && !req_i.we) begin
      region = RegionRom;
    end else if (dram_hit) begin
      region = RegionDram;
    end else begin
      region = RegionErr;             // GPIO window, unmapped or ROM write
    end
  end

  assign offset = req_i.addr - ((region == RegionRom) ? RomBase : DramBase);

  assign mem_req_o.idx   = offset[ByteOffset +: IdxWidth];
  assign mem_req_o.we    = req_i.we;
  assign mem_req_o.wdata = req_i.wdata;
  assign mem_req_o.be    = req_i.be;

  // ------------------------------------------------------------
  // Handshake and routing
  // ------------------------------------------------------------
  assign req_ready_o = ready_en_q && (!state_q.valid || rsp_ready_i);
  assign accept      = req_valid_i && req_ready_o;

  assign rom_req_o  = accept && (region == RegionRom);
  assign dram_req_o = accept && (region == RegionDram);

  always_comb begin : p_state
    state_d = state_q;
    if (state_q.valid && rsp_ready_i) begin
      state_d.valid = 1'b0;           // Taken by the master
    end
    if (accept) begin
      state_d.valid  = 1'b1;
      state_d.rd     = !req_i.we;
      state_d.region = region;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q    <= '0;
      ready_en_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      ready_en_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Response
  // ------------------------------------------------------------
  // Targets hold their read word, so the response stays stable
  always_comb begin : p_rsp
    rsp_o.rdata = '0;
    rsp_o.err   = 1'b0;
    unique case (state_q.region)
      RegionRom:  rsp_o.rdata = rom_rdata_i;
      RegionDram: begin
        if (state_q.rd) begin
          rsp_o.rdata = dram_rdata_i;
        end
      end
      default:    rsp_o.err = 1'b1;
    endcase
  end

  assign rsp_valid_o = state_q.valid;

endmodule

//--- source/soc_map_pkg.sv
package soc_map_pkg;

  // ------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------
  localparam int unsigned AddrWidth = 64;
  localparam int unsigned WordBytes = 8;      // One bus word

  localparam int unsigned RomWords  = 16;
  localparam int unsigned DramWords = 1024;

  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  localparam logic [AddrWidth-1:0] RomBase    = 64'h0000_0000_0001_0000;
  localparam logic [AddrWidth-1:0] RomLength  = AddrWidth'(RomWords * WordBytes);

  // Nothing lives here, accesses get a decode error
  localparam logic [AddrWidth-1:0] GpioBase   = 64'h0000_0000_4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength = 64'h0000_0000_0000_1000;

  localparam logic [AddrWidth-1:0] DramBase   = 64'h0000_0000_8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = AddrWidth'(DramWords * WordBytes);

  // Last DRAM word doubles as exit mailbox
  localparam logic [AddrWidth-1:0] ExitAddr   = DramBase + DramLength - AddrWidth'(WordBytes);

  // ------------------------------------------------------------
  // Boot image and debug
  // ------------------------------------------------------------
  localparam logic [31:0] BootTag = 32'hB007_C0DE;

  localparam int unsigned NbHarts          = 2;
  localparam int unsigned DebugDelayCycles = 64;  // Cycles of boot code before debug

  // Target selected by the crossbar
  typedef enum logic [1:0] {
    RegionRom,
    RegionDram,
    RegionErr
  } region_e;

endpackage

//--- source/soc_top.sv
`timescale 1ns/1ps

module soc_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Request channel
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  bus_pkg::bus_req_t                   req_i,
  // Response channel
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output bus_pkg::bus_rsp_t                   rsp_o,
  // Debug
  input  logic [soc_map_pkg::NbHarts-1:0]     debug_req_i,
  input  logic                                debug_en_i,
  output logic [soc_map_pkg::NbHarts-1:0]     debug_req_o,
  output logic [31:0]                         exit_o
);
  import soc_map_pkg::*;
  import bus_pkg::*;

  logic                 rom_req;
  logic                 dram_req;
  mem_req_t             mem_req;
  logic [DataWidth-1:0] rom_rdata;
  logic [DataWidth-1:0] dram_rdata;

  mem_xbar i_mem_xbar (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .req_valid_i  ( req_valid_i ),
    .req_ready_o  ( req_ready_o ),
    .req_i        ( req_i       ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_ready_i  ( rsp_ready_i ),
    .rsp_o        ( rsp_o       ),
    .rom_req_o    ( rom_req     ),
    .dram_req_o   ( dram_req    ),
    .mem_req_o    ( mem_req     ),
    .rom_rdata_i  ( rom_rdata   ),
    .dram_rdata_i ( dram_rdata  )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i                         ),
    .req_i   ( rom_req                       ),
    .idx_i   ( mem_req.idx[RomIdxWidth-1:0]  ), // ROM only needs the low index bits
    .rdata_o ( rom_rdata                     )
  );

  main_memory i_main_memory (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( dram_req   ),
    .mem_i   ( mem_req    ),
    .rdata_o ( dram_rdata ),
    .exit_o  ( exit_o     )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- testbench/soc_top_asserts.sv
`timescale 1ns/1ps

module soc_top_asserts (
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic                            req_ready_i,
  input logic                            rsp_valid_i,
  input logic                            rsp_ready_i,
  input bus_pkg::bus_rsp_t               rsp_i,
  input logic [soc_map_pkg::NbHarts-1:0] debug_gated_i
);
  import soc_map_pkg::*;

  logic [7:0] boot_cycles_q;  // Rising edges since reset release, saturating

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_boot_cnt
    if (!rst_ni) begin
      boot_cycles_q <= '0;
    end else if (boot_cycles_q < 8'(DebugDelayCycles)) begin
      boot_cycles_q <= boot_cycles_q + 8'd1;
    end
  end

  // Held response
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i)))
    else $error("Response changed or dropped while not taken");

  a_no_accept_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_i && !rsp_ready_i) |-> !req_ready_i)
    else $error("Request accepted while a response is pending");

  a_debug_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (boot_cycles_q < 8'(DebugDelayCycles)) |-> (debug_gated_i == '0))
    else $error("Debug request passed inside the post-reset window");

endmodule

bind soc_top soc_top_asserts i_soc_top_asserts (
  .clk_i         ( clk_i       ),
  .rst_ni        ( rst_ni      ),
  .req_ready_i   ( req_ready_o ),
  .rsp_valid_i   ( rsp_valid_o ),
  .rsp_ready_i   ( rsp_ready_i ),
  .rsp_i         ( rsp_o       ),
  .debug_gated_i ( debug_req_o )
);

//--- testbench/tb_soc_top.sv
`timescale 1ns/1ps

module tb_soc_top;
  import soc_map_pkg::*;
  import bus_pkg::*;

  localparam time ClkPeriod   = 100ns;
  localparam time SampleDelay = 25ns;          // Outputs settled, well before the rising edge
  // Tests need about 350 cycles, the limit leaves a wide margin
  localparam int unsigned MaxCycles = 4000;
  localparam int unsigned StreamLen = 32;
  localparam int unsigned PoolSize  = 8;

  // Expected response of one transfer
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
    logic                 check_rdata;       // Write responses carry no data
  } exp_rsp_t;

  logic               clk_i;
  logic               rst_ni;
  logic               req_valid_i;
  logic               req_ready_o;
  bus_req_t           req_i;
  logic               rsp_valid_o;
  logic               rsp_ready_i;
  bus_rsp_t           rsp_o;
  logic [NbHarts-1:0] debug_req_i;
  logic               debug_en_i;
  logic [NbHarts-1:0] debug_req_o;
  logic [31:0]        exit_o;

  logic [DataWidth-1:0] dram_model [DramWords];  // Expected main memory contents
  int unsigned          check_count = 0;
  int unsigned          error_count = 0;
  int unsigned          cycle_count = 0;

  soc_top UUT (.*);

  initial begin : p_clk
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_and_finish();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  function automatic exp_rsp_t make_exp(input logic [DataWidth-1:0] rdata, input logic err,
                                        input logic check_rdata);
    exp_rsp_t e;
    e.rdata       = rdata;
    e.err         = err;
    e.check_rdata = check_rdata;
    return e;
  endfunction

  function automatic logic [DataWidth-1:0] byte_mask(input logic [StrbWidth-1:0] be);
    logic [DataWidth-1:0] mask;
    for (int b = 0; b < StrbWidth; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

  function automatic logic [DataWidth-1:0] rand_word();
    return {$urandom(), $urandom()};
  endfunction

  function automatic logic [AddrWidth-1:0] dram_addr(input int unsigned idx);
    return DramBase + AddrWidth'(idx) * AddrWidth'(StrbWidth);
  endfunction

  function automatic logic [AddrWidth-1:0] rom_addr(input int unsigned idx);
    return RomBase + AddrWidth'(idx) * AddrWidth'(StrbWidth);
  endfunction

  task automatic model_write(input int unsigned idx, input logic [DataWidth-1:0] wdata,
                             input logic [StrbWidth-1:0] be);
    logic [DataWidth-1:0] mask;
    mask            = byte_mask(be);
    dram_model[idx] = (dram_model[idx] & ~mask) | (wdata & mask);
  endtask

  // One transfer with the response taken at once, response due one cycle later
  task automatic single_access(input string name, input logic [AddrWidth-1:0] addr,
                               input logic we, input logic [DataWidth-1:0] wdata,
                               input logic [StrbWidth-1:0] be, input exp_rsp_t exp);
    @(negedge clk_i);
    rsp_ready_i = 1'b1;
    req_valid_i = 1'b1;
    req_i       = '{addr: addr, we: we, wdata: wdata, be: be};
    #(SampleDelay);
    while (!req_ready_o) begin
      @(negedge clk_i);
      #(SampleDelay);
    end
    @(negedge clk_i);              // Request went over on the last rising edge
    req_valid_i = 1'b0;
    check_value({name, " valid"}, 64'(1), 64'(rsp_valid_o));
    if (exp.check_rdata) begin
      check_value({name, " rdata"}, exp.rdata, rsp_o.rdata);
    end
    check_value({name, " err"}, 64'(exp.err), 64'(rsp_o.err));
  endtask

  task automatic dram_write(input string name, input int unsigned idx,
                            input logic [DataWidth-1:0] wdata, input logic [StrbWidth-1:0] be);
    model_write(idx, wdata, be);
    single_access(name, dram_addr(idx), 1'b1, wdata, be, make_exp('0, 1'b0, 1'b0));
  endtask

  task automatic dram_read(input string name, input int unsigned idx);
    single_access(name, dram_addr(idx), 1'b0, '0, '1, make_exp(dram_model[idx], 1'b0, 1'b1));
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_debug_window();
    for (int k = 0; k < DebugDelayCycles; k++) begin
      check_value("debug window", 64'(0), 64'(debug_req_o));
      @(negedge clk_i);
    end
    check_value("debug open", 64'(debug_req_i), 64'(debug_req_o));
  endtask

  task automatic test_rom();
    for (int i = 0; i < RomWords; i++) begin
      single_access("rom read", rom_addr(i), 1'b0, '0, '1,
                    make_exp({BootTag, 32'(i)}, 1'b0, 1'b1));
    end
    single_access("rom write", rom_addr(3), 1'b1, rand_word(), '1, make_exp('0, 1'b1, 1'b1));
  endtask

  task automatic test_dram_random();
    int unsigned idx [12];
    for (int i = 0; i < 12; i++) begin
      idx[i] = $urandom_range(DramWords - 2);  // Mailbox word stays out
      dram_write("dram full write", idx[i], rand_word(), '1);
    end
    for (int i = 0; i < 12; i++) begin
      dram_write("dram partial write", idx[i], rand_word(), StrbWidth'($urandom_range(255, 1)));
    end
    for (int i = 0; i < 12; i++) begin
      dram_read("dram read", idx[i]);
    end
  endtask

  task automatic test_decode_errors();
    single_access("gpio read", GpioBase, 1'b0, '0, '1, make_exp('0, 1'b1, 1'b1));
    single_access("gpio write", GpioBase + 64'h10, 1'b1, rand_word(), '1,
                  make_exp('0, 1'b1, 1'b1));
    single_access("unmapped read", 64'h0000_0000_2000_0000, 1'b0, '0, '1,
                  make_exp('0, 1'b1, 1'b1));
    single_access("past dram read", DramBase + DramLength, 1'b0, '0, '1,
                  make_exp('0, 1'b1, 1'b1));
    single_access("past rom read", RomBase + RomLength, 1'b0, '0, '1, make_exp('0, 1'b1, 1'b1));
  endtask

  task automatic test_backpressure();
    int unsigned          pool [PoolSize];
    exp_rsp_t             exp_q [$];
    exp_rsp_t             next_exp;
    exp_rsp_t             head_exp;
    bus_req_t             req;
    logic                 have_req;
    int unsigned          issued;
    int unsigned          received;
    int unsigned          stall;
    int unsigned          kind;
    int unsigned          idx;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] be;
    for (int i = 0; i < PoolSize; i++) begin
      pool[i] = $urandom_range(DramWords - 2);
    end
    have_req = 1'b0;
    issued   = 0;
    received = 0;
    stall    = 0;
    while (received < StreamLen) begin
      @(negedge clk_i);
      if (stall == 0) begin
        rsp_ready_i = 1'b1;
        stall       = $urandom_range(4);
      end else begin
        rsp_ready_i = 1'b0;
        stall--;
      end
      if (!have_req && issued < StreamLen) begin
        kind = (issued < PoolSize) ? 0 : $urandom_range(3);  // Fill the pool first
        case (kind)
          0: begin
            idx   = (issued < PoolSize) ? pool[issued] : pool[$urandom_range(PoolSize - 1)];
            be    = (issued < PoolSize) ? '1 : StrbWidth'($urandom_range(255, 1));
            wdata = rand_word();
            model_write(idx, wdata, be);
            req      = '{addr: dram_addr(idx), we: 1'b1, wdata: wdata, be: be};
            next_exp = make_exp('0, 1'b0, 1'b0);
          end
          1: begin
            idx      = pool[$urandom_range(PoolSize - 1)];
            req      = '{addr: dram_addr(idx), we: 1'b0, wdata: '0, be: '1};
            next_exp = make_exp(dram_model[idx], 1'b0, 1'b1);
          end
          2: begin
            idx      = $urandom_range(RomWords - 1);
            req      = '{addr: rom_addr(idx), we: 1'b0, wdata: '0, be: '1};
            next_exp = make_exp({BootTag, 32'(idx)}, 1'b0, 1'b1);
          end
          default: begin
            req      = '{addr: GpioBase + 64'h8, we: 1'b0, wdata: '0, be: '1};
            next_exp = make_exp('0, 1'b1, 1'b1);
          end
        endcase
        have_req = 1'b1;
      end
      req_valid_i = have_req;
      req_i       = req;
      #(SampleDelay);
      if (rsp_valid_o && !rsp_ready_i) begin
        check_value("stall ready", 64'(0), 64'(req_ready_o));
      end
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: response seen with no request outstanding in back-pressure test");
          error_count++;
        end else begin
          head_exp = exp_q.pop_front();
          if (head_exp.check_rdata) begin
            check_value("stream rdata", head_exp.rdata, rsp_o.rdata);
          end
          check_value("stream err", 64'(head_exp.err), 64'(rsp_o.err));
        end
        received++;
      end
      if (req_valid_i && req_ready_o) begin
        exp_q.push_back(next_exp);
        issued++;
        have_req = 1'b0;
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
  endtask

  task automatic test_exit();
    int unsigned          exit_idx;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] mask;
    logic [StrbWidth-1:0] be;
    exit_idx = int'((ExitAddr - DramBase) / StrbWidth);
    wdata    = rand_word();
    dram_write("exit full write", exit_idx, wdata, '1);
    check_value("exit full", 64'(wdata[31:0]), 64'(exit_o));
    wdata = rand_word();
    be    = 8'b0110_1001;
    mask  = byte_mask(be);
    dram_write("exit partial write", exit_idx, wdata, be);
    check_value("exit partial", 64'(wdata[31:0] & mask[31:0]), 64'(exit_o));
    dram_read("exit read", exit_idx);
  endtask

  task automatic test_debug_follow();
    for (int k = 0; k < 8; k++) begin
      @(negedge clk_i);
      debug_req_i = NbHarts'($urandom());
      debug_en_i  = k[0];
      #(SampleDelay);
      check_value("debug follow", 64'(debug_en_i ? debug_req_i : {NbHarts{1'b0}}),
                  64'(debug_req_o));
    end
    @(negedge clk_i);
    debug_req_i = '0;
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial begin : p_main
    void'($urandom(79815));
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    debug_req_i = '1;           // Requests pending from the start
    debug_en_i  = 1'b1;
    repeat (8) @(negedge clk_i);
    check_value("reset rsp_valid", 64'(0), 64'(rsp_valid_o));
    check_value("reset req_ready", 64'(0), 64'(req_ready_o));
    check_value("reset debug_req", 64'(0), 64'(debug_req_o));
    check_value("reset exit", 64'(0), 64'(exit_o));
    rst_ni = 1'b1;
    test_debug_window();
    test_rom();
    test_dram_random();
    test_decode_errors();
    test_backpressure();
    test_exit();
    test_debug_follow();
    report_and_finish();
  end

  initial begin : p_watchdog
    while (cycle_count < MaxCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("ERROR: timeout, tests did not finish within %0d cycles", MaxCycles);
    error_count++;
    report_and_finish();
  end

endmodule
